// File: echo_pkg.sv
`default_nettype none

package echo_pkg;

    // ring geometry
    localparam int RING_DEPTH = 128;
    localparam int PAGE_COUNT = 8;

    localparam int SAMPLE_BITS = 8;
    localparam int INDEX_BITS = $clog2(RING_DEPTH);
    localparam int PAGE_BITS = $clog2(PAGE_COUNT);

    // the sample is written this many slots behind the read index
    localparam int WRITE_LAG = 2;

    typedef logic [SAMPLE_BITS-1:0] sample_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [PAGE_BITS-1:0] page_t;

    // largest value a sample can hold
    localparam sample_t SAMPLE_MAX = '1;

    // reset contents of the ring
    localparam sample_t RESET_HEAD = 8'hA0;
    localparam int RESET_BASE = 32;

    // index and tap right after reset
    localparam index_t RESET_INDEX = 7'd1;
    localparam sample_t RESET_TAP = sample_t'(RESET_BASE);

    // controller to ring request
    // save and restore are never high together
    typedef struct packed {
        logic save;
        logic restore;
        page_t page;
    } snap_req_t;

    // one full copy of the ring
    typedef sample_t ring_t [RING_DEPTH];

endpackage

`default_nettype wire

// File: snapshot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module snapshot_ctrl (
    input wire logic clk,
    input wire logic reset,

    // command strobe, low restore means save
    input wire logic cmd_strobe,
    input wire logic cmd_restore,
    input wire echo_pkg::page_t cmd_page,

    output echo_pkg::snap_req_t snap_req,
    output logic restore_miss
);

    import echo_pkg::*;

    // one flag per page, set on save
    logic [PAGE_COUNT-1:0] saved_q;

    snap_req_t req_d;
    logic miss_d;
    logic page_saved;

    assign page_saved = saved_q[cmd_page];

    // decode the strobe into a request
    always_comb begin
        req_d = '0;
        miss_d = 1'b0;
        if (cmd_strobe) begin
            if (!cmd_restore) begin
                req_d.save = 1'b1;
                req_d.page = cmd_page;
            end else if (page_saved) begin
                req_d.restore = 1'b1;
                req_d.page = cmd_page;
            end else begin
                // nothing to reload from, drop it
                miss_d = 1'b1;
            end
        end
    end

    // request lasts exactly one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            snap_req <= '0;
        end else begin
            snap_req <= req_d;
        end
    end

    // saved page tracking
    always_ff @(posedge clk) begin
        if (reset) begin
            saved_q <= '0;
        end else if (req_d.save) begin
            saved_q[req_d.page] <= 1'b1;
        end
    end

    // sticky until reset
    always_ff @(posedge clk) begin
        if (reset) begin
            restore_miss <= 1'b0;
        end else if (miss_d) begin
            restore_miss <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: delay_ring.sv
`timescale 1ns/1ps
`default_nettype none

module delay_ring (
    input wire logic clk,
    input wire logic reset,

    input wire echo_pkg::sample_t sample_in,
    input wire echo_pkg::snap_req_t snap_req,

    output echo_pkg::sample_t tap
);

    import echo_pkg::*;

    // live ring and its read index
    ring_t ring_q;
    index_t index_q;

    // snapshot pages
    ring_t page_q [PAGE_COUNT];

    ring_t ring_d;
    ring_t page_sel;
    index_t write_idx;
    index_t next_idx;
    sample_t tap_d;

    // index arithmetic wraps at the ring depth
    assign write_idx = index_q - index_t'(WRITE_LAG);
    assign next_idx = index_q + index_t'(1);

    // page addressed by the current request
    always_comb begin
        for (int i = 0; i < RING_DEPTH; i++) begin
            page_sel[i] = page_q[snap_req.page][i];
        end
    end

    // next ring contents
    always_comb begin
        for (int i = 0; i < RING_DEPTH; i++) begin
            if (snap_req.restore) begin
                ring_d[i] = page_sel[i];
            end else begin
                ring_d[i] = ring_q[i];
            end
        end
        // live sample wins over the reload
        ring_d[write_idx] = sample_in;
    end

    // tap reads from the page on a restore
    always_comb begin
        if (snap_req.restore) begin
            tap_d = page_sel[index_q];
        end else begin
            tap_d = ring_q[index_q];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < RING_DEPTH; i++) begin
                ring_q[i] <= sample_t'(RESET_BASE + i);
            end
            ring_q[0] <= RESET_HEAD;
        end else begin
            ring_q <= ring_d;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            index_q <= RESET_INDEX;
            tap <= RESET_TAP;
        end else begin
            index_q <= next_idx;
            tap <= tap_d;
        end
    end

    // a save copies the ring as it was before this cycle's write
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < PAGE_COUNT; p++) begin
                for (int i = 0; i < RING_DEPTH; i++) begin
                    page_q[p][i] <= '0;
                end
            end
        end else if (snap_req.save) begin
            for (int i = 0; i < RING_DEPTH; i++) begin
                page_q[snap_req.page][i] <= ring_q[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: echo_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module echo_mixer #(
    parameter int unsigned ECHO_SHIFT = 1
) (
    input wire logic clk,
    input wire logic reset,

    input wire echo_pkg::sample_t sample_in,
    input wire echo_pkg::sample_t tap,

    output echo_pkg::sample_t mix_out
);

    import echo_pkg::*;

    // dry path lines up with the registered tap
    sample_t dry_q;

    sample_t wet;
    logic [SAMPLE_BITS:0] sum;
    sample_t mix_d;

    // attenuation by a power of two
    assign wet = tap >> ECHO_SHIFT;

    // one spare bit for the carry
    assign sum = {1'b0, dry_q} + {1'b0, wet};

    // clip at full scale
    assign mix_d = sum[SAMPLE_BITS] ? SAMPLE_MAX : sum[SAMPLE_BITS-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            dry_q <= '0;
        end else begin
            dry_q <= sample_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mix_out <= '0;
        end else begin
            mix_out <= mix_d;
        end
    end

endmodule

`default_nettype wire

// File: echo_top.sv
`timescale 1ns/1ps
`default_nettype none

module echo_top #(
    parameter int unsigned ECHO_SHIFT = 1
) (
    input wire logic clk,
    input wire logic reset,

    // one sample per cycle
    input wire echo_pkg::sample_t sample_in,

    // snapshot command
    input wire logic cmd_strobe,
    input wire logic cmd_restore,
    input wire echo_pkg::page_t cmd_page,

    output echo_pkg::sample_t mix_out,
    output logic restore_miss
);

    import echo_pkg::*;

    snap_req_t snap_req;
    sample_t tap;

    // command decode and page tracking
    snapshot_ctrl i_snapshot_ctrl (
        .clk(clk),
        .reset(reset),
        .cmd_strobe(cmd_strobe),
        .cmd_restore(cmd_restore),
        .cmd_page(cmd_page),
        .snap_req(snap_req),
        .restore_miss(restore_miss)
    );

    // delay line with snapshot pages
    delay_ring i_delay_ring (
        .clk(clk),
        .reset(reset),
        .sample_in(sample_in),
        .snap_req(snap_req),
        .tap(tap)
    );

    // dry plus attenuated tap
    echo_mixer #(
        .ECHO_SHIFT(ECHO_SHIFT)
    ) i_echo_mixer (
        .clk(clk),
        .reset(reset),
        .sample_in(sample_in),
        .tap(tap),
        .mix_out(mix_out)
    );

endmodule

`default_nettype wire

// File: echo_checker.sv
`timescale 1ns/1ps
`default_nettype none

module echo_checker (
    input wire logic clk,
    input wire logic reset,
    input wire logic cmd_strobe,
    input wire echo_pkg::snap_req_t snap_req,
    input wire logic restore_miss
);

    // one command kind per request
    no_double_req: assert property (
        @(posedge clk) disable iff (reset)
        !(snap_req.save && snap_req.restore)
    ) else $error("save and restore requested in the same cycle");

    // sticky until reset
    miss_sticky: assert property (
        @(posedge clk) disable iff (reset)
        $fell(restore_miss) |-> $past(reset)
    ) else $error("restore_miss cleared without a reset");

    // a request only follows a strobe
    req_after_strobe: assert property (
        @(posedge clk) disable iff (reset)
        (snap_req.save || snap_req.restore) |-> $past(cmd_strobe)
    ) else $error("snapshot request without a strobe one cycle earlier");

endmodule

`default_nettype wire

// File: tb_echo_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_echo_top;

    import echo_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 4;
    localparam int ECHO_SHIFT = 1;

    localparam int RAMP_RUN = 20;
    localparam int DELAY_RUN = 300;
    localparam int SETTLE_RUN = 50;
    localparam int AFTER_RUN = 200;
    localparam int MISS_RUN = 100;
    localparam int SAT_RUN = 300;
    localparam int RANDOM_RUN = 1000;

    // every drive takes one clock, each reset takes one more than its length
    localparam int RESET_TASK_CYCLES = RESET_CYCLES + 1;
    localparam int TEST_CYCLES = 2 * RESET_TASK_CYCLES + RAMP_RUN + DELAY_RUN
        + SETTLE_RUN + AFTER_RUN + 2 + MISS_RUN + 1 + SAT_RUN + RANDOM_RUN;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 200;

    logic clk;
    logic reset;
    sample_t sample_in;
    logic cmd_strobe;
    logic cmd_restore;
    page_t cmd_page;
    sample_t mix_out;
    logic restore_miss;

    int seed;
    int error_count;
    int check_count;
    int test_num;
    int test_start_errors;
    string test_name;
    logic checking;

    // model state
    sample_t m_ring [RING_DEPTH];
    sample_t m_pages [PAGE_COUNT][RING_DEPTH];
    logic [PAGE_COUNT-1:0] m_saved;
    snap_req_t m_req;
    logic m_miss;
    index_t m_index;
    sample_t m_tap;
    sample_t m_dry;
    sample_t m_mix;

    echo_top #(
        .ECHO_SHIFT(ECHO_SHIFT)
    ) i_echo_top (
        .clk(clk),
        .reset(reset),
        .sample_in(sample_in),
        .cmd_strobe(cmd_strobe),
        .cmd_restore(cmd_restore),
        .cmd_page(cmd_page),
        .mix_out(mix_out),
        .restore_miss(restore_miss)
    );

    bind snapshot_ctrl echo_checker i_echo_checker (
        .clk(clk),
        .reset(reset),
        .cmd_strobe(cmd_strobe),
        .snap_req(snap_req),
        .restore_miss(restore_miss)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // dry plus attenuated tap, clipped at full scale
    function automatic sample_t expected_mix(input sample_t dry, input sample_t tap);
        int total;
        total = int'(dry) + (int'(tap) >> ECHO_SHIFT);
        if (total > 255) begin
            return 8'hFF;
        end
        return sample_t'(total);
    endfunction

    function automatic sample_t random_sample();
        return sample_t'($random(seed));
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic model_reset();
        m_ring[0] = RESET_HEAD;
        for (int i = 1; i < RING_DEPTH; i++) begin
            m_ring[i] = sample_t'(RESET_BASE + i);
        end
        for (int p = 0; p < PAGE_COUNT; p++) begin
            for (int i = 0; i < RING_DEPTH; i++) begin
                m_pages[p][i] = '0;
            end
        end
        m_saved = '0;
        m_req = '0;
        m_miss = 1'b0;
        m_index = index_t'(1);
        m_tap = sample_t'(RESET_BASE);
        m_dry = '0;
        m_mix = '0;
    endtask

    // model follows the inputs as they stood before this edge
    always @(posedge clk) begin : model_update
        index_t wr_slot;
        sample_t next_tap;
        if (reset) begin
            model_reset();
        end else begin
            m_mix = expected_mix(m_dry, m_tap);
            m_dry = sample_in;
            wr_slot = m_index - index_t'(2);
            if (m_req.restore) begin
                next_tap = m_pages[m_req.page][m_index];
            end else begin
                next_tap = m_ring[m_index];
            end
            // page takes the ring before this edge's write
            if (m_req.save) begin
                for (int i = 0; i < RING_DEPTH; i++) begin
                    m_pages[m_req.page][i] = m_ring[i];
                end
            end
            if (m_req.restore) begin
                for (int i = 0; i < RING_DEPTH; i++) begin
                    m_ring[i] = m_pages[m_req.page][i];
                end
            end
            m_ring[wr_slot] = sample_in;
            m_tap = next_tap;
            m_index = m_index + index_t'(1);
            m_req = '0;
            if (cmd_strobe) begin
                if (!cmd_restore) begin
                    m_req.save = 1'b1;
                    m_req.page = cmd_page;
                    m_saved[cmd_page] = 1'b1;
                end else if (m_saved[cmd_page]) begin
                    m_req.restore = 1'b1;
                    m_req.page = cmd_page;
                end else begin
                    m_miss = 1'b1;
                end
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (checking) begin
            check_value("mix_out", 32'(mix_out), 32'(m_mix));
            check_value("restore_miss", 32'(restore_miss), 32'(m_miss));
        end
    end

    task automatic drive_cycle(input sample_t s, input logic strobe, input logic restore,
                               input page_t page);
        @(posedge clk);
        sample_in <= s;
        cmd_strobe <= strobe;
        cmd_restore <= restore;
        cmd_page <= page;
    endtask

    task automatic reset_dut();
        @(posedge clk);
        reset <= 1'b1;
        sample_in <= '0;
        cmd_strobe <= 1'b0;
        cmd_restore <= 1'b0;
        cmd_page <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_num++;
        test_name = name;
        test_start_errors = error_count;
    endtask

    task automatic end_test();
        int errs;
        errs = error_count - test_start_errors;
        $display("test %0d %s: %s, %0d mismatches", test_num, test_name,
                 (errs == 0) ? "ok" : "failed", errs);
    endtask

    // reset contents come out at half value
    task automatic reset_ramp();
        for (int n = 1; n <= RAMP_RUN; n++) begin
            drive_cycle('0, 1'b0, 1'b0, '0);
            @(negedge clk);
            check_value("mix_out", 32'(mix_out),
                        32'(expected_mix('0, sample_t'(RESET_BASE + n - 1))));
        end
    endtask

    task automatic delay_line();
        sample_t hist [DELAY_RUN];
        for (int n = 0; n < DELAY_RUN; n++) begin
            hist[n] = random_sample();
            drive_cycle(hist[n], 1'b0, 1'b0, '0);
            @(negedge clk);
            // written one edge after driving, read 126 edges later
            if (n >= 127) begin
                check_value("tap", 32'(i_echo_top.tap), 32'(hist[n - 127]));
            end
        end
    endtask

    task automatic save_and_restore();
        drive_cycle(random_sample(), 1'b1, 1'b0, page_t'(3));
        repeat (SETTLE_RUN) drive_cycle(random_sample(), 1'b0, 1'b0, '0);
        drive_cycle(random_sample(), 1'b1, 1'b1, page_t'(3));
        repeat (AFTER_RUN) drive_cycle(random_sample(), 1'b0, 1'b0, '0);
    endtask

    task automatic missed_restore();
        drive_cycle(random_sample(), 1'b1, 1'b1, page_t'(6));
        repeat (MISS_RUN) drive_cycle(random_sample(), 1'b0, 1'b0, '0);
        @(negedge clk);
        check_value("restore_miss", 32'(restore_miss), 32'd1);
    endtask

    task automatic saturation();
        for (int n = 0; n < SAT_RUN; n++) begin
            drive_cycle(8'hFF, 1'b0, 1'b0, '0);
            @(negedge clk);
            if (n >= 2) begin
                check_value("mix_out", 32'(mix_out), 32'hFF);
            end
        end
    endtask

    task automatic random_commands();
        logic [31:0] r;
        @(negedge clk);
        check_value("restore_miss", 32'(restore_miss), 32'd0);
        for (int n = 0; n < RANDOM_RUN; n++) begin
            r = $random(seed);
            drive_cycle(r[15:8], r[3:0] == 4'd0, r[4], r[7:5]);
        end
    endtask

    initial begin
        reset = 1'b1;
        sample_in = '0;
        cmd_strobe = 1'b0;
        cmd_restore = 1'b0;
        cmd_page = '0;
        seed = 87;
        error_count = 0;
        check_count = 0;
        test_num = 0;
        checking = 1'b0;

        reset_dut();
        checking = 1'b1;

        begin_test("reset ramp");
        reset_ramp();
        end_test();

        begin_test("delay line");
        delay_line();
        end_test();

        begin_test("save and restore");
        save_and_restore();
        end_test();

        begin_test("missed restore");
        missed_restore();
        end_test();

        begin_test("saturation");
        saturation();
        end_test();

        begin_test("random commands");
        reset_dut();
        random_commands();
        end_test();

        @(negedge clk);
        $display("tests %0d, checks %0d, errors %0d", test_num, check_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
echo_pkg.sv
snapshot_ctrl.sv
delay_ring.sv
echo_mixer.sv
echo_top.sv
echo_checker.sv
tb_echo_top.sv

// File: Makefile
TOOL       := verilator
TOP        := tb_echo_top
FLIST      := flist.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := TESTBENCH FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
